/* Makefile */
# Verilator build and run of the immediate-decode testbench

TOP := decode_tb

.PHONY: all build run lint clean

all: run

build: obj_dir/V$(TOP)

obj_dir/V$(TOP): sim.f verilog/*.sv verif/decode_tb.sv
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir

# The log is searched for the pass line, so a failing run fails make
run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* sim.f */
verilog/qupls_pkg.sv
verilog/fp_cvt32_to_64.sv
verilog/decode_imm.sv
verilog/ins_window.sv
verilog/decode_top.sv
verif/decode_tb.sv

/* verif/decode_stimulus.txt */
// Columns: parcel0..parcel7 (slots past the group are 0), parcel count, has bits {A,B,C},
// imma, immb, immc, group length. An all-zero line ends the stream.
FFF1230A1484 0 0 0 0 0 0 0 1 2 0 FFFFFFFFFFFFF123 0 1
00F0F0000108 0 0 0 0 0 0 0 1 2 0 FFFFFFFFFF00F0F0 0 1
812345000209 0 0 0 0 0 0 0 1 2 0 812345 0 1
5A0EAF000007 0 0 0 0 0 0 0 1 2 0 3ABC 0 1
385EA0000002 0 0 0 0 0 0 0 1 2 0 FFFFFFFFFFFFFEF5 0 1
000400001043 0 0 0 0 0 0 0 1 2 0 400 0 1
FF8000000028 0 0 0 0 0 0 0 1 1 0 0 FFFFFFFFFFFFFF00 1
ABCDEF00030A 0 0 0 0 0 0 0 1 2 0 ABCDEF 0 1
80000000004B 0 0 0 0 0 0 0 1 2 0 FFFFFFFFFF800000 0 1
080000123402 0089ABCDEF30 0 0 0 0 0 0 2 4 FFFFFFFF89ABCDEF 0 0 2
000000000080 001234567834 0 0 0 0 0 0 2 2 0 12345678 0 2
002000000028 007FFF000038 0 0 0 0 0 0 2 1 0 0 7FFF0000 2
000010000004 00DEADBEEF34 0 0 0 0 0 0 2 2 0 FFFFFFFFDEADBEEF 0 2
000000000080 001122334430 00AABBCCDD30 0 0 0 0 0 3 4 AABBCCDD11223344 0 0 3
000001000009 008000000034 000000000134 0 0 0 0 0 3 2 0 0000000180000000 0 3
000000000080 00FFFFFFFE38 000000ABCD38 0 0 0 0 0 3 1 0 0 0000ABCDFFFFFFFE 3
080000123402 00000011220E 000000000530 0 0 0 0 0 3 4 5 0 0 3
000000000080 00000011220E 008000000138 0 0 0 0 0 3 1 0 0 FFFFFFFF80000001 3
7FFFFF000004 00000011220E 0 0 0 0 0 0 2 2 0 7FFFFF 0 2
000000000080 000000000130 000000000234 000000000338 0 0 0 0 4 7 1 2 3 4
FFFFFF000005 00000011220E 000123456730 0089ABCDEF30 00FEDCBA9834 007654321034 000F0F0F0F38 00F0F0F0F038 8 7 89ABCDEF01234567 76543210FEDCBA98 F0F0F0F00F0F0F0F 8
000000000080 00000011220E 004000000030 000000123438 000000567838 0 0 0 5 5 40000000 0 0000567800001234 5
01000000000C 003F80000030 00C020000034 007F80000038 0 0 0 0 4 7 3FF0000000000000 C004000000000000 7FF0000000000000 4
01000000000C 008000000030 0 0 0 0 0 0 2 4 8000000000000000 0 0 2
01000000000C 00FF80000030 0 0 0 0 0 0 2 4 FFF0000000000000 0 0 2
01000000000C 007FC0000030 0 0 0 0 0 0 2 4 7FF8000000000000 0 0 2
01000000000C 007F80000130 0 0 0 0 0 0 2 4 7FF8000020000000 0 0 2
01000000000C 000000000130 0 0 0 0 0 0 2 4 36A0000000000000 0 0 2
01000000000C 000030000030 0 0 0 0 0 0 2 4 37F8000000000000 0 0 2
01000000000C 000040000030 0 0 0 0 0 0 2 4 3800000000000000 0 0 2
01000000000C 007F7FFFFF30 0 0 0 0 0 0 2 4 47EFFFFFE0000000 0 0 2
01000000000C 000000000030 0 0 0 0 0 0 2 4 0 0 0 2
00800000000C 003F80000030 0 0 0 0 0 0 2 4 000000003F800000 0 0 2
0 0 0 0 0 0 0 0 0 0 0 0 0 0

/* verif/decode_tb.sv */
/*
  Self-checking testbench for decode_top.
  Groups and expected results come from verif/decode_stimulus.txt, so the
  simulation must be started from the project root.
  A group only decodes once the window is full, so the stream is closed
  with eight NOP parcels. The run stops at the first error.
*/
`default_nettype none

module decode_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// ========================================
	// Stimulus layout
	// ========================================

	// Words per line: eight parcels, count, has bits, A, B, C, length
	localparam int LINE_W     = 14;
	localparam int MAX_GROUPS = 48;
	localparam int TIMEOUT    = 200;
	localparam int W_COUNT    = 8;
	localparam int W_HAS      = 9;
	localparam int W_IMMA     = 10;
	localparam int W_IMMB     = 11;
	localparam int W_IMMC     = 12;
	localparam int W_LEN      = 13;

	logic        clk;
	logic        rst_n;
	logic        ins_valid;
	logic [47:0] ins_data;
	logic        ins_ready;
	logic        res_valid;
	logic [6:0]  res_opcode;
	logic [3:0]  res_len;
	logic [63:0] imma;
	logic [63:0] immb;
	logic [63:0] immc;
	logic        has_imma;
	logic        has_immb;
	logic        has_immc;

	logic [63:0] stim_mem [0:LINE_W*MAX_GROUPS-1];
	int          num_groups;
	integer      seed;

	decode_top #(
		.SUPPORT_POSTFIX (1'b1)
	) decode_top_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.ins_valid  (ins_valid),
		.ins_data   (ins_data),
		.ins_ready  (ins_ready),
		.res_valid  (res_valid),
		.res_opcode (res_opcode),
		.res_len    (res_len),
		.imma       (imma),
		.immb       (immb),
		.immc       (immc),
		.has_imma   (has_imma),
		.has_immb   (has_immb),
		.has_immc   (has_immc)
	);

	// 100 ns period, clk starts low in the main block
	always #50 clk = ~clk;

	// ========================================
	// Helpers
	// ========================================

	function automatic logic [63:0] stim_word(input int g, input int w);
		return stim_mem[g*LINE_W + w];
	endfunction

	task automatic abort_run;
		$display("SOME TESTS FAILED");
		$fatal(1, "decode_tb stopped at the first error");
	endtask

	task automatic check_field(input string name, input string where,
		input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp)
		else
		begin
			$display("Mismatch %s: got 0x%h, expected 0x%h (%s)", name, got, exp, where);
			abort_run();
		end
	endtask

	task automatic load_stimulus;
		logic [63:0] cnt;

		$readmemh("verif/decode_stimulus.txt", stim_mem);
		num_groups = 0;
		cnt = stim_word(0, W_COUNT);
		// An all-zero line closes the list of groups
		while (cnt !== 64'd0)
		begin
			if ($isunknown(cnt) || cnt > 64'd8)
			begin
				$display("Stimulus group %0d has a bad parcel count", num_groups);
				abort_run();
			end
			num_groups++;
			if (num_groups == MAX_GROUPS)
			begin
				$display("Stimulus file has no end line within %0d groups", MAX_GROUPS);
				abort_run();
			end
			cnt = stim_word(num_groups, W_COUNT);
		end
		if (num_groups == 0)
		begin
			$display("Stimulus file holds no groups");
			abort_run();
		end
	endtask

	// Nothing has been sent yet, so the result side must look idle
	task automatic check_reset_state;
		for (int n = 0; n < 4; n++)
		begin
			@(negedge clk);
			check_field("res_valid", "after reset", 64'(res_valid), 64'd0);
			check_field("ins_ready", "after reset", 64'(ins_ready), 64'd1);
			check_field("has_imma", "after reset", 64'(has_imma), 64'd0);
			check_field("has_immb", "after reset", 64'(has_immb), 64'd0);
			check_field("has_immc", "after reset", 64'(has_immc), 64'd0);
		end
	endtask

	// ========================================
	// Driver
	// ========================================

	// Called on a rising edge, returns on the edge that moved the parcel
	task automatic send_parcel(input logic [47:0] p);
		int gap;
		int waited;

		gap = int'($unsigned($random(seed)) % 4);
		repeat (gap)
		begin
			ins_valid <= 1'b0;
			@(posedge clk);
		end
		ins_valid <= 1'b1;
		ins_data  <= p;
		waited = 0;
		// ins_ready only moves on a clock edge, so mid-cycle is a safe sample point
		@(negedge clk);
		while (!ins_ready)
		begin
			waited++;
			if (waited >= TIMEOUT)
			begin
				$display("Timeout: ins_ready stayed low for %0d cycles", TIMEOUT);
				abort_run();
			end
			@(negedge clk);
		end
		@(posedge clk);
	endtask

	task automatic drive_stream;
		logic [63:0] word;
		int          cnt;

		for (int g = 0; g < num_groups; g++)
		begin
			cnt = int'(stim_word(g, W_COUNT));
			for (int p = 0; p < cnt; p++)
			begin
				word = stim_word(g, p);
				send_parcel(word[47:0]);
			end
		end
		// Trailing NOPs fill the window behind the last real group
		for (int n = 0; n < 8; n++)
			send_parcel(48'd0);
		ins_valid <= 1'b0;
	endtask

	// ========================================
	// Monitor
	// ========================================

	task automatic collect_results;
		int          waited;
		string       where;
		logic [63:0] head;
		logic [63:0] has_exp;

		for (int g = 0; g < num_groups; g++)
		begin
			waited = 0;
			@(negedge clk);
			while (!res_valid)
			begin
				waited++;
				if (waited >= TIMEOUT)
				begin
					$display("Timeout: no result for group %0d within %0d cycles", g, TIMEOUT);
					abort_run();
				end
				@(negedge clk);
			end
			where   = $sformatf("group %0d", g);
			head    = stim_word(g, 0);
			has_exp = stim_word(g, W_HAS);
			// The head opcode sits in the low seven bits of the first parcel
			check_field("res_opcode", where, 64'(res_opcode), {57'd0, head[6:0]});
			check_field("res_len", where, 64'(res_len), stim_word(g, W_LEN));
			check_field("has_imma", where, 64'(has_imma), {63'd0, has_exp[2]});
			check_field("has_immb", where, 64'(has_immb), {63'd0, has_exp[1]});
			check_field("has_immc", where, 64'(has_immc), {63'd0, has_exp[0]});
			check_field("imma", where, imma, stim_word(g, W_IMMA));
			check_field("immb", where, immb, stim_word(g, W_IMMB));
			check_field("immc", where, immc, stim_word(g, W_IMMC));
		end
	endtask

	initial
	begin
		clk       = 1'b0;
		rst_n     = 1'b0;
		ins_valid = 1'b0;
		ins_data  = 48'd0;
		seed      = 32'h3d8c_984d;
		load_stimulus();
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		check_reset_state();
		@(posedge clk);
		fork
			drive_stream();
			collect_results();
		join
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/decode_imm.sv */
/*
  Immediate decoder for the head of the alignment window.
  Postfixes must follow in A, B, C order after at most one vector qualifier.
  A second postfix of the same kind only sets bits 63..32.
  Slot reads past the window return an all-zero parcel, which is a NOP.
  Purely combinational, grp_len is always 1..WIN_DEPTH.
*/
`default_nettype none

module decode_imm
	import qupls_pkg::*;
#(
	parameter bit SUPPORT_POSTFIX = 1'b1
) (
	input  wire parcel_t [WIN_DEPTH-1:0] win_slots,
	output logic [63:0]                  imma,
	output logic [63:0]                  immb,
	output logic [63:0]                  immc,
	output logic                         has_imma,
	output logic                         has_immb,
	output logic                         has_immc,
	output logic [LEN_W-1:0]             grp_len
);

	// ========================================
	// Helpers
	// ========================================

	function automatic parcel_t slot_at(input parcel_t [WIN_DEPTH-1:0] s,
		input logic [LEN_W-1:0] i);
		if (i < LEN_W'(WIN_DEPTH))
			return s[i[PTR_W-1:0]];
		return '0;
	endfunction

	function automatic opcode_e op_of(input parcel_t p);
		return opcode_e'(p[6:0]);
	endfunction

	// Postfix opcode for operand k, where 0 is A, 1 is B and 2 is C
	function automatic opcode_e pfx_kind(input int k);
		case (k)
			0: return OP_PFXA32;
			1: return OP_PFXB32;
			default: return OP_PFXC32;
		endcase
	endfunction

	parcel_t               head;
	opcode_e               head_op;
	func_e                 head_fn;
	logic                  flt_dp;
	logic [23:0]           imm24;
	logic [LEN_W-1:0]      ndx;
	logic [2:0]            pfx_hit;
	logic [2:0]            pfx_dbl;
	logic [2:0][LEN_W-1:0] pfx_pos;
	parcel_t [2:0]         pfx_first;
	parcel_t [2:0]         pfx_second;
	logic [2:0][31:0]      pfx_lo;
	logic [2:0][31:0]      pfx_hi;
	logic [2:0][63:0]      cvt_y;
	logic [2:0][63:0]      imm;
	logic [2:0]            has;

	assign head    = win_slots[0];
	assign head_op = op_of(head);
	assign head_fn = func_e'(head[FUNC_LSB +: 7]);
	assign imm24   = head[IMM24_LSB +: 24];
	// Three-operand float at double precision takes converted postfixes
	assign flt_dp  = (head_op == OP_FLT3) && (head[FLTPR_LSB +: 2] == 2'd2);

	// ========================================
	// Postfix scan and group length
	// ========================================

	always_comb
	begin
		ndx     = LEN_W'(1);
		pfx_hit = '0;
		pfx_dbl = '0;
		pfx_pos = '0;
		// One vector qualifier may sit between the head and its postfixes
		if (op_of(slot_at(win_slots, ndx)) == OP_VEC)
			ndx = ndx + 1'b1;
		if (SUPPORT_POSTFIX)
		begin
			for (int k = 0; k < 3; k++)
			begin
				if (op_of(slot_at(win_slots, ndx)) == pfx_kind(k))
				begin
					pfx_hit[k] = 1'b1;
					pfx_pos[k] = ndx;
					ndx = ndx + 1'b1;
					// A repeat of the same kind carries the upper half
					if (op_of(slot_at(win_slots, ndx)) == pfx_kind(k))
					begin
						pfx_dbl[k] = 1'b1;
						ndx = ndx + 1'b1;
					end
				end
			end
		end
		grp_len = ndx;
	end

	// Payloads of the first and second postfix of each kind, and their conversion
	for (genvar k = 0; k < 3; k++)
	begin : g_pfx
		assign pfx_first[k]  = slot_at(win_slots, pfx_pos[k]);
		assign pfx_second[k] = slot_at(win_slots, pfx_pos[k] + 1'b1);
		assign pfx_lo[k]     = pfx_first[k][PFX_LSB +: 32];
		assign pfx_hi[k]     = pfx_second[k][PFX_LSB +: 32];

		fp_cvt32_to_64 cvt_inst (
			.a (pfx_lo[k]),
			.y (cvt_y[k])
		);
	end

	// ========================================
	// Immediate selection
	// ========================================

	always_comb
	begin
		imm = '0;
		has = '0;
		// Immediate carried by the head format itself
		case (head_op)
			OP_ADDI, OP_CMPI, OP_LDO, OP_STO:
			begin
				imm[1] = {{40{imm24[23]}}, imm24};
				has[1] = 1'b1;
			end
			OP_ORI, OP_EORI:
			begin
				imm[1] = {40'd0, imm24};
				has[1] = 1'b1;
			end
			OP_ANDI:
			begin
				// Upper ones leave the high bits of the register untouched
				imm[1] = {{40{1'b1}}, imm24};
				has[1] = 1'b1;
			end
			OP_CSR:
			begin
				imm[1] = {50'd0, head[CSR_LSB +: 14]};
				has[1] = 1'b1;
			end
			OP_R2:
			begin
				if (head_fn == FN_BYTENDX)
				begin
					imm[1] = {{54{head[BNDX_LSB + 9]}}, head[BNDX_LSB +: 10]};
					has[1] = 1'b1;
				end
			end
			OP_BCC:
			begin
				imm[2] = {{47{head[BR_LSB + 16]}}, head[BR_LSB +: 17]};
				has[2] = 1'b1;
			end
			default:
				;
		endcase
		// A postfix wins over the head immediate of the same operand
		for (int k = 0; k < 3; k++)
		begin
			if (pfx_hit[k])
			begin
				has[k] = 1'b1;
				if (flt_dp)
					imm[k] = cvt_y[k];
				else
					imm[k] = {{32{pfx_lo[k][31]}}, pfx_lo[k]};
				if (pfx_dbl[k])
					imm[k][63:32] = pfx_hi[k];
			end
		end
	end

	assign imma     = imm[0];
	assign immb     = imm[1];
	assign immc     = imm[2];
	assign has_imma = has[0];
	assign has_immb = has[1];
	assign has_immc = has[2];

	// The window shifts by this amount, so it must stay inside the window
	always_comb
	begin
		a_grp_len_range: assert (grp_len >= LEN_W'(1) && grp_len <= LEN_W'(WIN_DEPTH))
			else $error("decode_imm group length %0d out of range", grp_len);
	end

endmodule

`default_nettype wire

/* verilog/decode_top.sv */
/*
  Immediate-decode slice: alignment window, decoder and result register.
  res_valid pulses for one cycle per decoded group. There is no
  downstream back-pressure, so results must be taken when they appear.
  The stream end must be padded with NOPs to flush the last group.
*/
`default_nettype none

module decode_top
	import qupls_pkg::*;
#(
	parameter bit SUPPORT_POSTFIX = 1'b1
) (
	input  wire logic             clk,
	input  wire logic             rst_n,
	input  wire logic             ins_valid,
	input  wire parcel_t          ins_data,
	output logic                  ins_ready,
	output logic                  res_valid,
	output opcode_e               res_opcode,
	output logic [LEN_W-1:0]      res_len,
	output logic [63:0]           imma,
	output logic [63:0]           immb,
	output logic [63:0]           immc,
	output logic                  has_imma,
	output logic                  has_immb,
	output logic                  has_immc
);

	parcel_t [WIN_DEPTH-1:0] win_slots;
	logic                    win_full;
	logic [LEN_W-1:0]        grp_len;
	logic [63:0]             dec_imma;
	logic [63:0]             dec_immb;
	logic [63:0]             dec_immc;
	logic                    dec_has_imma;
	logic                    dec_has_immb;
	logic                    dec_has_immc;

	ins_window ins_window_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.ins_valid (ins_valid),
		.ins_data  (ins_data),
		.ins_ready (ins_ready),
		.win_slots (win_slots),
		.win_full  (win_full),
		.grp_len   (grp_len)
	);

	decode_imm #(
		.SUPPORT_POSTFIX (SUPPORT_POSTFIX)
	) decode_imm_inst (
		.win_slots (win_slots),
		.imma      (dec_imma),
		.immb      (dec_immb),
		.immc      (dec_immc),
		.has_imma  (dec_has_imma),
		.has_immb  (dec_has_immb),
		.has_immc  (dec_has_immc),
		.grp_len   (grp_len)
	);

	// ========================================
	// Result register
	// ========================================

	// Valid and the has bits are the record's control state
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			res_valid <= 1'b0;
			has_imma  <= 1'b0;
			has_immb  <= 1'b0;
			has_immc  <= 1'b0;
		end
		else
		begin
			res_valid <= win_full;
			if (win_full)
			begin
				has_imma <= dec_has_imma;
				has_immb <= dec_has_immb;
				has_immc <= dec_has_immc;
			end
		end
	end

	// Payload is captured on the same edge as the window drop
	always_ff @(posedge clk)
	begin
		if (win_full)
		begin
			res_opcode <= opcode_e'(win_slots[0][6:0]);
			res_len    <= grp_len;
			imma       <= dec_imma;
			immb       <= dec_immb;
			immc       <= dec_immc;
		end
	end

endmodule

`default_nettype wire

/* verilog/fp_cvt32_to_64.sv */
/*
  Combinational IEEE-754 single to double precision conversion.
  The conversion is exact, so no rounding is needed. NaNs come out quiet
  with the upper 22 payload bits kept. Subnormal inputs are normalized.
*/
`default_nettype none

module fp_cvt32_to_64 (
	input  wire logic [31:0] a,
	output logic      [63:0] y
);

	logic        sgn;
	logic [7:0]  exp_s;
	logic [22:0] man_s;
	logic [4:0]  lz;
	logic [22:0] man_n;

	assign sgn   = a[31];
	assign exp_s = a[30:23];
	assign man_s = a[22:0];

	// Leading-zero count of the single fraction, only meaningful for subnormals
	always_comb
	begin
		lz = 5'd0;
		// Ascending scan so the highest set bit sets the final count
		for (int i = 0; i < 23; i++)
		begin
			if (man_s[i])
				lz = 5'(22 - i);
		end
		// Shift out the leading one, which becomes the hidden bit
		man_n = man_s << (lz + 5'd1);
	end

	always_comb
	begin
		if (exp_s == 8'hFF)
		begin
			// Infinity keeps a zero fraction, NaN is forced quiet
			if (man_s == 23'd0)
				y = {sgn, 11'h7FF, 52'd0};
			else
				y = {sgn, 11'h7FF, 1'b1, man_s[21:0], 29'd0};
		end
		else if (exp_s == 8'h00)
		begin
			if (man_s == 23'd0)
				y = {sgn, 63'd0};
			else
				// Top fraction bit set means 2^-127, which is biased 896 in double
				y = {sgn, 11'd896 - {6'd0, lz}, man_n, 29'd0};
		end
		else
		begin
			// Bias moves from 127 to 1023
			y = {sgn, {3'b000, exp_s} + 11'd896, man_s, 29'd0};
		end
	end

endmodule

`default_nettype wire

/* verilog/ins_window.sv */
/*
  Alignment window of WIN_DEPTH parcels, slot 0 is the group head.
  Accepts at most one parcel per clock. When full, drops grp_len parcels
  on the same edge and may take a new parcel into the freed space.
  A drop always frees a slot, so ins_ready stays high.
*/
`default_nettype none

module ins_window
	import qupls_pkg::*;
(
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire logic                    ins_valid,
	input  wire parcel_t                 ins_data,
	output logic                         ins_ready,
	output parcel_t [WIN_DEPTH-1:0]      win_slots,
	output logic                         win_full,
	input  wire logic [LEN_W-1:0]        grp_len
);

	logic [LEN_W-1:0]       count;
	logic [LEN_W-1:0]       count_n;
	logic [LEN_W-1:0]       drop;
	logic [LEN_W-1:0]       remain;
	logic                   take;
	parcel_t [WIN_DEPTH-1:0] slots_q;
	parcel_t [WIN_DEPTH-1:0] slots_n;

	assign win_full  = (count == LEN_W'(WIN_DEPTH));
	assign ins_ready = (count < LEN_W'(WIN_DEPTH)) || win_full;
	assign take      = ins_valid && ins_ready;
	assign win_slots = slots_q;

	// Decode consumes a group only when every slot is valid
	assign drop    = win_full ? grp_len : '0;
	assign remain  = count - drop;
	assign count_n = remain + LEN_W'(take);

	// ========================================
	// Slot shift and append
	// ========================================

	always_comb
	begin
		logic [LEN_W-1:0] src;

		// Move the surviving parcels toward the head
		for (int i = 0; i < WIN_DEPTH; i++)
		begin
			src = LEN_W'(i) + drop;
			if (src < LEN_W'(WIN_DEPTH))
				slots_n[i] = slots_q[src[PTR_W-1:0]];
			else
				slots_n[i] = slots_q[i];
		end
		// The new parcel lands just behind the last surviving one
		if (take)
			slots_n[remain[PTR_W-1:0]] = ins_data;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			count <= '0;
		else
			count <= count_n;
	end

	// Slots beyond count hold stale parcels and are never decoded
	always_ff @(posedge clk)
	begin
		slots_q <= slots_n;
	end

	// ========================================
	// Checks
	// ========================================

	// The decoder must never ask for more parcels than the window holds
	a_drop_fits: assert property (@(posedge clk) disable iff (!rst_n)
		win_full |-> (grp_len <= count))
		else $error("ins_window drop of %0d exceeds count %0d", grp_len, count);

	// A zero drop would leave a full window stuck on the same head
	a_drop_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		win_full |-> (grp_len != '0))
		else $error("ins_window full with a zero drop");

endmodule

`default_nettype wire

/* verilog/qupls_pkg.sv */
/*
  Shared definitions for the immediate-decode slice of the front end.
  Opcode encodings are local to this slice and only cover the forms that
  the immediate decoder knows about. An all-zero parcel decodes as OP_NOP.
  Field positions are bit offsets into one 48-bit parcel.
*/
`default_nettype none

package qupls_pkg;

	// ========================================
	// Sizes
	// ========================================

	// One instruction parcel
	localparam int PARCEL_W = 48;
	// Longest group is head, vector qualifier and two postfixes of each kind
	localparam int WIN_DEPTH = 8;
	// Slot index width and group length width (length runs 1..WIN_DEPTH)
	localparam int PTR_W = $clog2(WIN_DEPTH);
	localparam int LEN_W = $clog2(WIN_DEPTH + 1);

	typedef logic [PARCEL_W-1:0] parcel_t;

	// ========================================
	// Field positions
	// ========================================

	// Opcode lives in bits 6..0 of every parcel, function in 47..41 of R2
	localparam int FUNC_LSB = 41;
	// 24-bit immediate of the ALU, load and store forms, bits 47..24
	localparam int IMM24_LSB = 24;
	// Byte index field of R2 BYTENDX, bits 38..29
	localparam int BNDX_LSB = 29;
	// CSR number, bits 35..22
	localparam int CSR_LSB = 22;
	// Branch displacement, bits 47..31
	localparam int BR_LSB = 31;
	// Postfix payload, bits 39..8
	localparam int PFX_LSB = 8;
	// Float precision of FLT3, bits 40..39, where 2 means double
	localparam int FLTPR_LSB = 39;

	// ========================================
	// Encodings
	// ========================================

	typedef enum logic [6:0] {
		OP_NOP    = 7'h00,
		OP_R2     = 7'h02,
		OP_ADDI   = 7'h04,
		OP_CMPI   = 7'h05,
		OP_CSR    = 7'h07,
		OP_ANDI   = 7'h08,
		OP_ORI    = 7'h09,
		OP_EORI   = 7'h0A,
		OP_FLT3   = 7'h0C,
		OP_VEC    = 7'h0E,
		OP_BCC    = 7'h28,
		OP_PFXA32 = 7'h30,
		OP_PFXB32 = 7'h34,
		OP_PFXC32 = 7'h38,
		OP_LDO    = 7'h43,
		OP_STO    = 7'h4B
	} opcode_e;

	// Only the R2 functions that matter to immediate decode
	typedef enum logic [6:0] {
		FN_ADD     = 7'h04,
		FN_BYTENDX = 7'h1C
	} func_e;

endpackage

`default_nettype wire
